// ==== logic/mem_map_pkg.sv ====
`default_nettype none

package mem_map_pkg;

    // ------------------------------------------------
    // Address regions from the top two address bits
    // ------------------------------------------------
    localparam int REGION_MSB = 31;
    localparam int REGION_LSB = 30;

    typedef enum logic [1:0] {
        REGION_NONE_LO = 2'b00,
        REGION_DMEM    = 2'b01,
        REGION_MMIO    = 2'b10,
        REGION_NONE_HI = 2'b11
    } region_t;

    // ------------------------------------------------
    // MMIO register offsets, word index in addr[4:2]
    // ------------------------------------------------
    localparam logic [2:0] MMIO_OFS_STATUS    = 3'd0;
    localparam logic [2:0] MMIO_OFS_UART_RX   = 3'd1;
    localparam logic [2:0] MMIO_OFS_UART_TX   = 3'd2;
    // Offset 3 is a hole and reads zero
    localparam logic [2:0] MMIO_OFS_CNT_CLEAR = 3'd4;
    localparam logic [2:0] MMIO_OFS_CYCLES    = 3'd5;
    localparam logic [2:0] MMIO_OFS_ACCESSES  = 3'd6;

endpackage

`default_nettype wire

// ==== logic/access_pkg.sv ====
`default_nettype none

package access_pkg;

    // ------------------------------------------------
    // Load/store width codes, funct3 style
    // ------------------------------------------------
    typedef enum logic [2:0] {
        WIDTH_B  = 3'd0,
        WIDTH_H  = 3'd1,
        WIDTH_W  = 3'd2,
        WIDTH_BU = 3'd4,
        WIDTH_HU = 3'd5
    } width_t;

    // ------------------------------------------------
    // Handshake sequencer states
    // ------------------------------------------------
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_ACCESS  = 2'd1,
        ST_RESPOND = 2'd2,
        ST_RELEASE = 2'd3
    } fsm_state_t;

endpackage

`default_nettype wire

// ==== logic/access_fsm.sv ====
`default_nettype none
`timescale 1ns/10ps

module access_fsm (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            req,
    input  wire logic [1:0]      region_bits,
    output logic                 ack,
    output logic                 dmem_en,
    output logic                 mmio_en,
    output logic                 access_done,
    output mem_map_pkg::region_t rsp_region
);

    access_pkg::fsm_state_t state;
    access_pkg::fsm_state_t state_next;

    // ------------------------------------------------
    // Next state
    // ------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            access_pkg::ST_IDLE: begin
                if (req) begin
                    state_next = access_pkg::ST_ACCESS;
                end
            end
            access_pkg::ST_ACCESS:  state_next = access_pkg::ST_RESPOND;
            access_pkg::ST_RESPOND: state_next = access_pkg::ST_RELEASE;
            access_pkg::ST_RELEASE: begin
                // Back-pressure, wait here until the requester lets go
                if (!req) begin
                    state_next = access_pkg::ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= access_pkg::ST_IDLE;
            rsp_region  <= mem_map_pkg::REGION_NONE_LO;
            access_done <= 1'b0;
        end else begin
            state       <= state_next;
            // Pulse lines up with the first ack cycle
            access_done <= (state == access_pkg::ST_RESPOND);
            // Region captured once per transaction
            if (state == access_pkg::ST_IDLE && req) begin
                rsp_region <= mem_map_pkg::region_t'(region_bits);
            end
        end
    end

    // ------------------------------------------------
    // Outputs
    // ------------------------------------------------
    assign dmem_en = (state == access_pkg::ST_ACCESS) &&
                     (rsp_region == mem_map_pkg::REGION_DMEM);
    assign mmio_en = (state == access_pkg::ST_ACCESS) &&
                     (rsp_region == mem_map_pkg::REGION_MMIO);
    assign ack     = (state == access_pkg::ST_RELEASE);

endmodule

`default_nettype wire

// ==== logic/perf_counters.sv ====
`default_nettype none
`timescale 1ns/10ps

module perf_counters #(
    parameter int COUNT_WIDTH = 32
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   access_done,
    input  wire logic                   cnt_clear,
    output logic [COUNT_WIDTH-1:0]      cycle_count,
    output logic [COUNT_WIDTH-1:0]      access_count
);

    // ------------------------------------------------
    // Free-running cycle count and completed accesses
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || cnt_clear) begin
            cycle_count  <= '0;
            access_count <= '0;
        end else begin
            cycle_count  <= cycle_count + COUNT_WIDTH'(1);
            if (access_done) begin
                access_count <= access_count + COUNT_WIDTH'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/dmem_array.sv ====
`default_nettype none
`timescale 1ns/10ps

module dmem_array #(
    parameter int DMEM_ADDR_WIDTH = 10
) (
    input  wire logic                       clk,
    input  wire logic                       dmem_en,
    input  wire logic                       we,
    input  wire logic [DMEM_ADDR_WIDTH-1:0] word_addr,
    input  wire logic [1:0]                 byte_ofs,
    input  access_pkg::width_t              width,
    input  wire logic [31:0]                wdata,
    output logic [31:0]                     rdata
);

    localparam int DEPTH = 1 << DMEM_ADDR_WIDTH;

    logic [31:0] mem [DEPTH];
    logic [31:0] wdata_shifted;
    logic [3:0]  byte_en;

    // ------------------------------------------------
    // Store alignment
    // ------------------------------------------------
    // Moves the low bytes up to their lane
    assign wdata_shifted = wdata << {byte_ofs, 3'b000};

    always_comb begin
        case (width)
            access_pkg::WIDTH_B,
            access_pkg::WIDTH_BU: byte_en = 4'b0001 << byte_ofs;
            access_pkg::WIDTH_H,
            access_pkg::WIDTH_HU: byte_en = 4'b0011 << byte_ofs;
            default:              byte_en = 4'b1111;
        endcase
    end

    // ------------------------------------------------
    // Word RAM, read-before-write
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (dmem_en) begin
            if (we) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (byte_en[lane]) begin
                        mem[word_addr][lane*8 +: 8] <= wdata_shifted[lane*8 +: 8];
                    end
                end
            end
            rdata <= mem[word_addr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/mmio_regs.sv ====
`default_nettype none
`timescale 1ns/10ps

module mmio_regs #(
    parameter int COUNT_WIDTH = 32
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   mmio_en,
    input  wire logic                   we,
    input  wire logic [2:0]             reg_ofs,
    input  wire logic [31:0]            wdata,
    input  wire logic [COUNT_WIDTH-1:0] cycle_count,
    input  wire logic [COUNT_WIDTH-1:0] access_count,
    input  wire logic [7:0]             uart_rx_data,
    input  wire logic                   uart_rx_valid,
    input  wire logic                   uart_tx_ready,
    input  wire logic                   access_done,
    output logic [31:0]                 rdata,
    output logic                        cnt_clear,
    output logic [7:0]                  uart_tx_data,
    output logic                        uart_tx_strobe,
    output logic                        uart_rx_taken
);

    logic tx_pending;
    logic rx_pending;

    // ------------------------------------------------
    // Writes and pending UART events
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_clear  <= 1'b0;
            tx_pending <= 1'b0;
            rx_pending <= 1'b0;
        end else begin
            if (access_done) begin
                tx_pending <= 1'b0;
                rx_pending <= 1'b0;
            end
            if (mmio_en && we && reg_ofs == mem_map_pkg::MMIO_OFS_CNT_CLEAR) begin
                cnt_clear <= wdata[0];
            end
            if (mmio_en && we && reg_ofs == mem_map_pkg::MMIO_OFS_UART_TX) begin
                tx_pending <= 1'b1;
            end
            if (mmio_en && !we && reg_ofs == mem_map_pkg::MMIO_OFS_UART_RX) begin
                rx_pending <= 1'b1;
            end
        end
    end

    // Transmit byte
    always_ff @(posedge clk) begin
        if (mmio_en && we && reg_ofs == mem_map_pkg::MMIO_OFS_UART_TX) begin
            uart_tx_data <= wdata[7:0];
        end
    end

    // ------------------------------------------------
    // Registered read
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (mmio_en && !we) begin
            case (reg_ofs)
                mem_map_pkg::MMIO_OFS_STATUS:   rdata <= {30'd0, uart_rx_valid, uart_tx_ready};
                mem_map_pkg::MMIO_OFS_UART_RX:  rdata <= {24'd0, uart_rx_data};
                mem_map_pkg::MMIO_OFS_CYCLES:   rdata <= 32'(cycle_count);
                mem_map_pkg::MMIO_OFS_ACCESSES: rdata <= 32'(access_count);
                default:                        rdata <= 32'd0;
            endcase
        end
    end

    // Strobes fire together with the first ack cycle
    assign uart_tx_strobe = tx_pending && access_done;
    assign uart_rx_taken  = rx_pending && access_done;

endmodule

`default_nettype wire

// ==== logic/load_align.sv ====
`default_nettype none
`timescale 1ns/10ps

module load_align (
    input  wire logic [31:0]      dmem_rdata,
    input  wire logic [31:0]      mmio_rdata,
    input  mem_map_pkg::region_t  rsp_region,
    input  wire logic [1:0]       byte_ofs,
    input  access_pkg::width_t    width,
    output logic [31:0]           rdata
);

    logic [31:0] src;
    logic [31:0] shifted;

    // ------------------------------------------------
    // Source select by region
    // ------------------------------------------------
    always_comb begin
        case (rsp_region)
            mem_map_pkg::REGION_DMEM:     src = dmem_rdata;
            mem_map_pkg::REGION_MMIO:     src = mmio_rdata;
            mem_map_pkg::REGION_NONE_LO,
            mem_map_pkg::REGION_NONE_HI:  src = 32'd0;
        endcase
    end

    // Addressed byte lands in bits 7:0
    assign shifted = src >> {byte_ofs, 3'b000};

    // ------------------------------------------------
    // Mask and extend
    // ------------------------------------------------
    always_comb begin
        case (width)
            access_pkg::WIDTH_B:  rdata = {{24{shifted[7]}}, shifted[7:0]};
            access_pkg::WIDTH_H:  rdata = {{16{shifted[15]}}, shifted[15:0]};
            access_pkg::WIDTH_BU: rdata = {24'd0, shifted[7:0]};
            access_pkg::WIDTH_HU: rdata = {16'd0, shifted[15:0]};
            default:              rdata = shifted;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/dmem_space.sv ====
`default_nettype none
`timescale 1ns/10ps

module dmem_space #(
    parameter int DMEM_ADDR_WIDTH = 10,
    parameter int COUNT_WIDTH     = 32
) (
    input  wire logic                clk,
    input  wire logic                rst,
    // Requester side
    input  wire logic                req,
    input  wire logic                we,
    input  wire logic [31:0]         addr,
    input  access_pkg::width_t       width,
    input  wire logic [31:0]         wdata,
    output logic                     ack,
    output logic [31:0]              rdata,
    // UART side
    input  wire logic [7:0]          uart_rx_data,
    input  wire logic                uart_rx_valid,
    input  wire logic                uart_tx_ready,
    output logic [7:0]               uart_tx_data,
    output logic                     uart_tx_strobe,
    output logic                     uart_rx_taken
);

    // ------------------------------------------------
    // Internal wires
    // ------------------------------------------------
    logic                   dmem_en;
    logic                   mmio_en;
    logic                   access_done;
    logic                   cnt_clear;
    mem_map_pkg::region_t   rsp_region;
    logic [31:0]            dmem_rdata;
    logic [31:0]            mmio_rdata;
    logic [COUNT_WIDTH-1:0] cycle_count;
    logic [COUNT_WIDTH-1:0] access_count;

    access_fsm access_fsm_inst (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .region_bits (addr[mem_map_pkg::REGION_MSB:mem_map_pkg::REGION_LSB]),
        .ack         (ack),
        .dmem_en     (dmem_en),
        .mmio_en     (mmio_en),
        .access_done (access_done),
        .rsp_region  (rsp_region)
    );

    perf_counters #(.COUNT_WIDTH(COUNT_WIDTH)) perf_counters_inst (
        .clk          (clk),
        .rst          (rst),
        .access_done  (access_done),
        .cnt_clear    (cnt_clear),
        .cycle_count  (cycle_count),
        .access_count (access_count)
    );

    // Word address skips the two byte-offset bits
    dmem_array #(.DMEM_ADDR_WIDTH(DMEM_ADDR_WIDTH)) dmem_array_inst (
        .clk       (clk),
        .dmem_en   (dmem_en),
        .we        (we),
        .word_addr (addr[DMEM_ADDR_WIDTH+1:2]),
        .byte_ofs  (addr[1:0]),
        .width     (width),
        .wdata     (wdata),
        .rdata     (dmem_rdata)
    );

    mmio_regs #(.COUNT_WIDTH(COUNT_WIDTH)) mmio_regs_inst (
        .clk            (clk),
        .rst            (rst),
        .mmio_en        (mmio_en),
        .we             (we),
        .reg_ofs        (addr[4:2]),
        .wdata          (wdata),
        .cycle_count    (cycle_count),
        .access_count   (access_count),
        .uart_rx_data   (uart_rx_data),
        .uart_rx_valid  (uart_rx_valid),
        .uart_tx_ready  (uart_tx_ready),
        .access_done    (access_done),
        .rdata          (mmio_rdata),
        .cnt_clear      (cnt_clear),
        .uart_tx_data   (uart_tx_data),
        .uart_tx_strobe (uart_tx_strobe),
        .uart_rx_taken  (uart_rx_taken)
    );

    load_align load_align_inst (
        .dmem_rdata (dmem_rdata),
        .mmio_rdata (mmio_rdata),
        .rsp_region (rsp_region),
        .byte_ofs   (addr[1:0]),
        .width      (width),
        .rdata      (rdata)
    );

endmodule

`default_nettype wire

// ==== tests/dmem_space_assertions.sv ====
`default_nettype none
`timescale 1ns/10ps

module dmem_space_assertions (
    input wire logic              clk,
    input wire logic              rst,
    input wire logic              req,
    input wire logic              ack,
    input wire logic              dmem_en,
    input wire logic              mmio_en,
    input access_pkg::fsm_state_t state
);

    // ------------------------------------------------
    // Four-phase handshake
    // ------------------------------------------------
    ack_low_after_reset: assert property (@(posedge clk) rst |=> !ack)
        else begin
            $error("ack is high in the cycle after reset");
            dmem_space_tb.assert_errors = dmem_space_tb.assert_errors + 1;
        end

    ack_rises_with_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
        else begin
            $error("ack rose while req was low");
            dmem_space_tb.assert_errors = dmem_space_tb.assert_errors + 1;
        end

    ack_falls_after_req: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> !$past(req))
        else begin
            $error("ack fell while req was still high");
            dmem_space_tb.assert_errors = dmem_space_tb.assert_errors + 1;
        end

    // ------------------------------------------------
    // Access enables
    // ------------------------------------------------
    enables_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(dmem_en && mmio_en))
        else begin
            $error("dmem_en and mmio_en are high together");
            dmem_space_tb.assert_errors = dmem_space_tb.assert_errors + 1;
        end

    // One access cycle per transaction and only straight out of idle
    enables_single_cycle: assert property (@(posedge clk) disable iff (rst)
        (dmem_en || mmio_en) |-> $past(state) == access_pkg::ST_IDLE ##1 !(dmem_en || mmio_en))
        else begin
            $error("an access enable stayed high for more than one cycle");
            dmem_space_tb.assert_errors = dmem_space_tb.assert_errors + 1;
        end

endmodule

`default_nettype wire

// ==== tests/dmem_space_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module dmem_space_tb;

    typedef struct {
        logic               we;
        logic [31:0]        addr;
        access_pkg::width_t width;
        logic [31:0]        wdata;
        logic [9:0]         uart_in;
        logic [31:0]        exp_rdata;
        logic               rising;
    } entry_t;

    logic               clk;
    logic               rst;
    logic               req;
    logic               we;
    logic [31:0]        addr;
    access_pkg::width_t width;
    logic [31:0]        wdata;
    logic               ack;
    logic [31:0]        rdata;
    logic [7:0]         uart_rx_data;
    logic               uart_rx_valid;
    logic               uart_tx_ready;
    logic [7:0]         uart_tx_data;
    logic               uart_tx_strobe;
    logic               uart_rx_taken;

    entry_t      stim_q[$];
    logic [31:0] dmem_model [1024];
    logic        clear_model = 1'b0;
    int          access_model = 0;
    logic [31:0] last_cycles = 32'd0;
    int          errors = 0;
    int          assert_errors = 0;
    int          tx_total = 0;
    int          rx_total = 0;
    int          tb_cycles = 0;
    int          cycle_limit = 100;
    integer      seed = 81;

    access_pkg::width_t store_widths [7] = '{access_pkg::WIDTH_B, access_pkg::WIDTH_B,
        access_pkg::WIDTH_B, access_pkg::WIDTH_B, access_pkg::WIDTH_H, access_pkg::WIDTH_H,
        access_pkg::WIDTH_W};
    logic [1:0] store_offsets [7] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd2, 2'd0};
    access_pkg::width_t load_widths [5] = '{access_pkg::WIDTH_B, access_pkg::WIDTH_H,
        access_pkg::WIDTH_W, access_pkg::WIDTH_BU, access_pkg::WIDTH_HU};

    dmem_space dmem_space_inst (
        .clk(clk), .rst(rst), .req(req), .we(we), .addr(addr), .width(width),
        .wdata(wdata), .ack(ack), .rdata(rdata), .uart_rx_data(uart_rx_data),
        .uart_rx_valid(uart_rx_valid), .uart_tx_ready(uart_tx_ready),
        .uart_tx_data(uart_tx_data), .uart_tx_strobe(uart_tx_strobe),
        .uart_rx_taken(uart_rx_taken)
    );

    bind access_fsm dmem_space_assertions handshake_checks (
        .clk(clk), .rst(rst), .req(req), .ack(ack),
        .dmem_en(dmem_en), .mmio_en(mmio_en), .state(state)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // UART pulses seen at mid-cycle
    always @(negedge clk) begin
        if (uart_tx_strobe) tx_total++;
        if (uart_rx_taken) rx_total++;
    end

    always @(posedge clk) begin
        tb_cycles++;
        if (tb_cycles > cycle_limit) begin
            $display("Timeout: no end of run after %0d cycles, a handshake hung", tb_cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic void log_failure(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        errors++;
    endfunction

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic [31:0] load_value(input logic [31:0] word, input logic [1:0] ofs,
                                               input access_pkg::width_t w);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[int'(ofs) * 8 +: 8];
        h = ofs[1] ? word[31:16] : word[15:0];
        case (w)
            access_pkg::WIDTH_B:  return 32'($signed(b));
            access_pkg::WIDTH_H:  return 32'($signed(h));
            access_pkg::WIDTH_BU: return {24'd0, b};
            access_pkg::WIDTH_HU: return {16'd0, h};
            default:              return word;
        endcase
    endfunction

    function automatic void store_model(input logic [31:0] a, input access_pkg::width_t w,
                                        input logic [31:0] d);
        int nbytes;
        nbytes = (w == access_pkg::WIDTH_W) ? 4 :
                 (w == access_pkg::WIDTH_H || w == access_pkg::WIDTH_HU) ? 2 : 1;
        for (int i = 0; i < nbytes; i++) begin
            dmem_model[a[11:2]][(int'(a[1:0]) + i) * 8 +: 8] = d[i * 8 +: 8];
        end
    endfunction

    // Expected values follow the model state at the point the entry is added
    function automatic void add_entry(input logic we_i, input logic [31:0] addr_i,
                                      input access_pkg::width_t width_i,
                                      input logic [31:0] wdata_i, input logic [9:0] uart_i);
        entry_t     e;
        logic [2:0] ofs;
        e.we = we_i;
        e.addr = addr_i;
        e.width = width_i;
        e.wdata = wdata_i;
        e.uart_in = uart_i;
        e.exp_rdata = 32'd0;
        e.rising = 1'b0;
        ofs = addr_i[4:2];
        case (mem_map_pkg::region_t'(addr_i[mem_map_pkg::REGION_MSB:mem_map_pkg::REGION_LSB]))
            mem_map_pkg::REGION_DMEM: begin
                if (we_i) store_model(addr_i, width_i, wdata_i);
                else e.exp_rdata = load_value(dmem_model[addr_i[11:2]], addr_i[1:0], width_i);
            end
            mem_map_pkg::REGION_MMIO: begin
                if (we_i && ofs == mem_map_pkg::MMIO_OFS_CNT_CLEAR) clear_model = wdata_i[0];
                if (!we_i) begin
                    case (ofs)
                        mem_map_pkg::MMIO_OFS_STATUS:   e.exp_rdata = {30'd0, uart_i[1:0]};
                        mem_map_pkg::MMIO_OFS_UART_RX:  e.exp_rdata = {24'd0, uart_i[9:2]};
                        mem_map_pkg::MMIO_OFS_ACCESSES: e.exp_rdata = 32'(access_model);
                        mem_map_pkg::MMIO_OFS_CYCLES:   e.rising = 1'b1;
                        default:                        e.exp_rdata = 32'd0;
                    endcase
                end
            end
            default: begin
            end
        endcase
        // Counter held at zero while the clear level is set
        if (clear_model) access_model = 0;
        else access_model++;
        stim_q.push_back(e);
    endfunction

    // --------------------------------------------------
    // One four-phase transaction entered at a falling edge
    // --------------------------------------------------
    task automatic run_entry(input entry_t e);
        logic [31:0] got;
        int          is_mmio;
        int          exp_tx;
        int          exp_rx;
        int          tx_before;
        int          rx_before;
        is_mmio = (e.addr[31:30] == mem_map_pkg::REGION_MMIO) ? 1 : 0;
        exp_tx = (is_mmio == 1 && e.we && e.addr[4:2] == mem_map_pkg::MMIO_OFS_UART_TX) ? 1 : 0;
        exp_rx = (is_mmio == 1 && !e.we && e.addr[4:2] == mem_map_pkg::MMIO_OFS_UART_RX) ? 1 : 0;
        tx_before = tx_total;
        rx_before = rx_total;
        req = 1'b1;
        we = e.we;
        addr = e.addr;
        width = e.width;
        wdata = e.wdata;
        {uart_rx_data, uart_rx_valid, uart_tx_ready} = e.uart_in;
        @(negedge clk);
        while (!ack) @(negedge clk);
        got = rdata;
        req = 1'b0;
        @(negedge clk);
        while (ack) @(negedge clk);
        if (!e.we && e.rising) begin
            assert (got > last_cycles)
                else log_failure($sformatf("cycle count %0d not above %0d", got, last_cycles));
            last_cycles = got;
        end else if (!e.we) begin
            assert (got === e.exp_rdata)
                else log_failure($sformatf("load %h width %0d gave %h, expected %h",
                                           e.addr, e.width, got, e.exp_rdata));
        end
        assert (tx_total - tx_before == exp_tx)
            else log_failure($sformatf("%0d tx strobes at %h", tx_total - tx_before, e.addr));
        assert (rx_total - rx_before == exp_rx)
            else log_failure($sformatf("%0d rx taken at %h", rx_total - rx_before, e.addr));
        if (exp_tx == 1) begin
            assert (uart_tx_data === e.wdata[7:0])
                else log_failure($sformatf("uart_tx_data %h, expected %h",
                                           uart_tx_data, e.wdata[7:0]));
        end
    endtask

    initial begin
        logic [31:0] base;
        logic [31:0] rnd;
        logic [1:0]  lofs;
        rst = 1'b1;
        req = 1'b0;
        we = 1'b0;
        addr = 32'd0;
        width = access_pkg::WIDTH_W;
        wdata = 32'd0;
        uart_rx_data = 8'd0;
        uart_rx_valid = 1'b0;
        uart_tx_ready = 1'b0;

        // DMEM stores of each width and offset followed by loads of all widths
        for (int s = 0; s < 7; s++) begin
            base = 32'h4000_0040 + 32'(s) * 32'd4;
            add_entry(1'b1, base, access_pkg::WIDTH_W, $random(seed), 10'd0);
            add_entry(1'b1, {base[31:2], store_offsets[s]}, store_widths[s], $random(seed), 10'd0);
            for (int l = 0; l < 5; l++) begin
                case (load_widths[l])
                    access_pkg::WIDTH_W: lofs = 2'd0;
                    access_pkg::WIDTH_H, access_pkg::WIDTH_HU: lofs = {store_offsets[s][1], 1'b0};
                    default: lofs = store_offsets[s];
                endcase
                add_entry(1'b0, {base[31:2], lofs}, load_widths[l], 32'd0, 10'd0);
            end
        end

        // MMIO registers
        add_entry(1'b0, 32'h8000_0018, access_pkg::WIDTH_W, 32'd0, 10'd0);
        add_entry(1'b1, 32'h8000_0008, access_pkg::WIDTH_W, $random(seed), 10'd0);
        add_entry(1'b1, 32'h8000_0008, access_pkg::WIDTH_W, $random(seed), 10'd0);
        for (int i = 0; i < 4; i++) begin
            add_entry(1'b0, 32'h8000_0000, access_pkg::WIDTH_W, 32'd0, {8'h5a, 2'(i)});
        end
        for (int i = 0; i < 2; i++) begin
            rnd = $random(seed);
            add_entry(1'b0, 32'h8000_0004, access_pkg::WIDTH_W, 32'd0, {rnd[7:0], 2'b10});
        end
        add_entry(1'b0, 32'h8000_000c, access_pkg::WIDTH_W, 32'd0, 10'd0);
        add_entry(1'b1, 32'h8000_0010, access_pkg::WIDTH_W, 32'd1, 10'd0);
        add_entry(1'b1, 32'h8000_0010, access_pkg::WIDTH_W, 32'd0, 10'd0);
        add_entry(1'b0, 32'h4000_0040, access_pkg::WIDTH_W, 32'd0, 10'd0);
        add_entry(1'b0, 32'h8000_0018, access_pkg::WIDTH_W, 32'd0, 10'd0);
        for (int i = 0; i < 3; i++) begin
            add_entry(1'b0, 32'h8000_0014, access_pkg::WIDTH_W, 32'd0, 10'd0);
        end

        // Unmapped regions, with UART inputs set so a stray MMIO decode reads nonzero
        add_entry(1'b0, 32'h0000_0040, access_pkg::WIDTH_W, 32'd0, 10'h3ff);
        add_entry(1'b0, 32'hc000_0044, access_pkg::WIDTH_W, 32'd0, 10'h3ff);
        add_entry(1'b1, 32'h0000_0040, access_pkg::WIDTH_W, $random(seed), 10'd0);
        add_entry(1'b1, 32'hc000_0044, access_pkg::WIDTH_W, $random(seed), 10'd0);
        add_entry(1'b0, 32'h4000_0040, access_pkg::WIDTH_W, 32'd0, 10'd0);
        add_entry(1'b0, 32'h4000_0044, access_pkg::WIDTH_W, 32'd0, 10'd0);
        add_entry(1'b0, 32'h8000_0018, access_pkg::WIDTH_W, 32'd0, 10'd0);
        cycle_limit = 20 * stim_q.size() + 100;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (stim_q[i]) begin
            run_entry(stim_q[i]);
        end

        $display("Check errors: %0d, assertion errors: %0d", errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dmem_space.f ====
logic/mem_map_pkg.sv
logic/access_pkg.sv
logic/access_fsm.sv
logic/perf_counters.sv
logic/dmem_array.sv
logic/mmio_regs.sv
logic/load_align.sv
logic/dmem_space.sv
tests/dmem_space_assertions.sv
tests/dmem_space_tb.sv

// ==== Makefile ====
# Verilator build and run for the dmem_space testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module dmem_space_tb \
		-f dmem_space.f -o dmem_space_sim

# The run is judged by the pass line in the log, not by the exit code
run: compile
	./obj_dir/dmem_space_sim +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
